//--- logic/motor_ctrl_pkg.sv
// ------------------------------
// shared address map, widths and bus types for the motor controller command path
// import into each stage that decodes or carries the write bus
// ------------------------------
`default_nettype none

package motor_ctrl_pkg;

    // ------------------------------
    // basic widths
    // ------------------------------
    typedef logic [15:0] addr_t;    // space[15:12], chan[7:4], offset[3:0]
    typedef logic [31:0] data_t;    // register data quadlet
    typedef logic [3:0]  chan_t;    // channel 0 = global regs
    typedef logic [15:0] cur_t;     // offset binary, cmd and feedback

    localparam int NUM_CHANNELS = 4;

    typedef logic [NUM_CHANNELS-1:0] amp_mask_t;            // bit i-1 -> channel i
    typedef logic [$clog2(NUM_CHANNELS)-1:0] chan_idx_t;    // zero based channel index

    // ------------------------------
    // address map
    // ------------------------------
    localparam logic [3:0] ADDR_MAIN    = 4'h0;   // main register space
    localparam logic [3:0] OFF_STATUS   = 4'h0;   // chan 0 status / amp disable
    localparam logic [3:0] OFF_DAC_CTRL = 4'h1;   // commanded current

    // merged or per-source write bus
    typedef struct packed {
        logic  reg_wen;      // quadlet write
        logic  blk_wen;      // end of block write
        logic  blk_wstart;   // block write starting
        addr_t addr;
        data_t data;
    } wr_bus_t;

    // ------------------------------
    // current and safety limits
    // ------------------------------
    localparam cur_t CUR_MID           = 16'h8000;  // zero current
    localparam cur_t SAFETY_MARGIN     = 16'h0100;  // slack on top of 2x cmd
    localparam int   SAFETY_TRIP_COUNT = 4;         // consecutive bad samples
    localparam int   SAFETY_CNT_W      = $clog2(SAFETY_TRIP_COUNT + 1);

    // ------------------------------
    // serial DAC
    // ------------------------------
    localparam int DAC_FRAME_BITS = 20;   // 4 bit chan + 16 bit cmd
    localparam int DAC_BIT_W      = $clog2(DAC_FRAME_BITS);
    localparam int DAC_GAP_CYCLES = 2;    // csel high between frames

    typedef logic [DAC_FRAME_BITS-1:0] dac_frame_t;

    typedef enum logic [1:0] {
        DAC_IDLE,
        DAC_SHIFT,
        DAC_GAP
    } dac_state_t;

endpackage

`default_nettype wire

//--- logic/write_bus_arbiter.sv
// ------------------------------
// picks one of three write sources by priority and registers it as the board write bus
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module write_bus_arbiter (
    input  wire                     sysclk,
    input  wire                     arst_n,
    input  wire motor_ctrl_pkg::wr_bus_t fw_wr,    // firewire, default owner
    input  wire motor_ctrl_pkg::wr_bus_t eth_wr,   // ethernet
    input  wire motor_ctrl_pkg::wr_bus_t bw_wr,    // real-time block writer
    input  wire                     eth_write_en,
    input  wire                     bw_write_en,
    output motor_ctrl_pkg::wr_bus_t      wr_bus
);
    import motor_ctrl_pkg::*;

    wr_bus_t sel_bus;   // combinational winner

    // ------------------------------
    // priority select
    // ------------------------------
    // bw over eth over fw; fw owns the bus when nobody else asks
    always_comb begin
        if (bw_write_en) begin
            sel_bus = bw_wr;        // addr already widened to 16 bits
        end else if (eth_write_en) begin
            sel_bus = eth_wr;
        end else begin
            sel_bus = fw_wr;
        end
    end

    // ------------------------------
    // output register
    // ------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_bus <= '0;           // no strobes out of reset
        end else begin
            wr_bus <= sel_bus;      // one cycle after source
        end
    end

endmodule

`default_nettype wire

//--- logic/cur_cmd_regs.sv
// ------------------------------
// per-channel commanded current registers plus the deferred DAC update request
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module cur_cmd_regs (
    input  wire                      sysclk,
    input  wire                      arst_n,
    input  wire motor_ctrl_pkg::wr_bus_t  wr_bus,
    input  wire                      dac_busy,
    output motor_ctrl_pkg::cur_t          cur_cmd [motor_ctrl_pkg::NUM_CHANNELS],
    output logic                     dac_update
);
    import motor_ctrl_pkg::*;

    chan_t     wr_chan;     // channel field of write addr
    chan_idx_t wr_idx;      // zero based slot
    logic      dac_hit;     // write targets a command reg
    logic      cmd_req;     // update pending

    // ------------------------------
    // address decode
    // ------------------------------
    assign wr_chan = wr_bus.addr[7:4];
    assign wr_idx  = chan_idx_t'(wr_chan - chan_t'(1));

    // chan 0 is global, anything past NUM_CHANNELS is ignored
    assign dac_hit = (wr_bus.addr[15:12] == ADDR_MAIN) &&
                     (wr_chan != chan_t'(0)) &&
                     (wr_chan <= chan_t'(NUM_CHANNELS)) &&
                     (wr_bus.addr[3:0] == OFF_DAC_CTRL);

    // fire as soon as the DAC is free
    assign dac_update = cmd_req & ~dac_busy;

    // ------------------------------
    // command storage and request
    // ------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                cur_cmd[i] <= CUR_MID;          // zero current
            end
            cmd_req <= 1'b0;
        end else begin
            if (dac_hit && wr_bus.reg_wen) begin
                cur_cmd[wr_idx] <= wr_bus.data[15:0];
            end
            // new block commit wins over the clear, so a commit
            // landing in the update cycle still gets its own update
            if (dac_hit && wr_bus.blk_wen) begin
                cmd_req <= 1'b1;
            end else if (dac_update) begin
                cmd_req <= 1'b0;                // taken by the DAC
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/dac_serializer.sv
// ------------------------------
// shifts the four captured commands to the serial DAC, one 20 bit frame per channel
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module dac_serializer (
    input  wire                  sysclk,
    input  wire                  arst_n,
    input  wire motor_ctrl_pkg::cur_t cur_cmd [motor_ctrl_pkg::NUM_CHANNELS],
    input  wire                  dac_update,
    output logic                 dac_busy,
    output logic                 dac_sclk,
    output logic                 dac_mosi,
    output logic                 dac_csel
);
    import motor_ctrl_pkg::*;

    dac_state_t           state;
    dac_frame_t           shift_reg;            // MSB goes out first
    logic [DAC_BIT_W-1:0] bit_cnt;              // bit within frame
    logic                 gap_cnt;              // csel high cycles
    chan_idx_t            chan_idx;             // frame being sent
    cur_t                 cmd_q [NUM_CHANNELS]; // snapshot at update

    assign dac_mosi = shift_reg[DAC_FRAME_BITS-1];

    // snapshot so later writes don't tear an update
    always_ff @(posedge sysclk) begin
        if (dac_update && (state == DAC_IDLE)) begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                cmd_q[i] <= cur_cmd[i];
            end
        end
    end

    // ------------------------------
    // frame FSM
    // ------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= DAC_IDLE;
            dac_busy  <= 1'b0;
            dac_sclk  <= 1'b0;
            dac_csel  <= 1'b1;
            shift_reg <= '0;
            bit_cnt   <= '0;
            gap_cnt   <= 1'b0;
            chan_idx  <= '0;
        end else begin
            case (state)
                DAC_IDLE: begin
                    if (dac_update) begin
                        dac_busy <= 1'b1;
                        chan_idx <= '0;
                        gap_cnt  <= 1'b0;
                        state    <= DAC_GAP;    // lead-in, csel still high
                    end
                end
                DAC_GAP: begin
                    if (gap_cnt == 1'(DAC_GAP_CYCLES - 1)) begin
                        // chan number (1 based) then its command
                        shift_reg <= {chan_t'(chan_idx) + chan_t'(1), cmd_q[chan_idx]};
                        bit_cnt   <= '0;
                        dac_csel  <= 1'b0;
                        state     <= DAC_SHIFT;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                DAC_SHIFT: begin
                    dac_sclk <= ~dac_sclk;      // sysclk / 2
                    if (dac_sclk) begin         // sclk about to fall, move data
                        if (bit_cnt == DAC_BIT_W'(DAC_FRAME_BITS - 1)) begin
                            dac_csel <= 1'b1;   // end of frame
                            gap_cnt  <= 1'b0;
                            chan_idx <= chan_idx + 1'b1;
                            if (chan_idx == chan_idx_t'(NUM_CHANNELS - 1)) begin
                                dac_busy <= 1'b0;
                                state    <= DAC_IDLE;
                            end else begin
                                state <= DAC_GAP;
                            end
                        end else begin
                            shift_reg <= {shift_reg[DAC_FRAME_BITS-2:0], 1'b0};
                            bit_cnt   <= bit_cnt + 1'b1;
                        end
                    end
                end
                default: state <= DAC_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/safety_monitor.sv
// ------------------------------
// over-current check per channel; latches amp disable until cleared by a status write
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module safety_monitor (
    input  wire                      sysclk,
    input  wire                      arst_n,
    input  wire motor_ctrl_pkg::wr_bus_t  wr_bus,
    input  wire motor_ctrl_pkg::cur_t     cur_cmd [motor_ctrl_pkg::NUM_CHANNELS],
    input  wire motor_ctrl_pkg::cur_t     cur_fb [motor_ctrl_pkg::NUM_CHANNELS],
    input  wire                      cur_ready,      // new adc sample set
    output motor_ctrl_pkg::amp_mask_t     amp_disable
);
    import motor_ctrl_pkg::*;

    amp_mask_t               over_lim;                // this sample is bad
    amp_mask_t               clr_mask;                // software clear
    logic                    clr_hit;
    logic [SAFETY_CNT_W-1:0] trip_cnt [NUM_CHANNELS]; // consecutive bad samples

    // magnitude around midscale
    function automatic cur_t mid_dist(input cur_t v);
        if (v >= CUR_MID) begin
            return v - CUR_MID;
        end
        return CUR_MID - v;
    endfunction

    // ------------------------------
    // limit compare
    // ------------------------------
    always_comb begin
        logic [16:0] limit;     // 2x cmd + margin, one extra bit
        logic [16:0] fb_mag;
        limit  = '0;
        fb_mag = '0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            limit       = {mid_dist(cur_cmd[i]), 1'b0} + {1'b0, SAFETY_MARGIN};
            fb_mag      = {1'b0, mid_dist(cur_fb[i])};
            over_lim[i] = fb_mag > limit;
        end
    end

    // status write on chan 0 clears selected bits
    assign clr_hit  = wr_bus.reg_wen && (wr_bus.addr[15:12] == ADDR_MAIN) &&
                      (wr_bus.addr[7:4] == chan_t'(0)) && (wr_bus.addr[3:0] == OFF_STATUS);
    assign clr_mask = clr_hit ? wr_bus.data[NUM_CHANNELS-1:0] : '0;

    // ------------------------------
    // trip counters and latch
    // ------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            amp_disable <= '0;
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                trip_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                if (clr_mask[i]) begin
                    amp_disable[i] <= 1'b0;     // clear beats a sample
                    trip_cnt[i]    <= '0;
                end else if (cur_ready) begin
                    if (!over_lim[i]) begin
                        trip_cnt[i] <= '0;      // run broken
                    end else if (trip_cnt[i] != SAFETY_CNT_W'(SAFETY_TRIP_COUNT)) begin
                        trip_cnt[i] <= trip_cnt[i] + 1'b1;  // saturates at trip
                        if (trip_cnt[i] == SAFETY_CNT_W'(SAFETY_TRIP_COUNT - 1)) begin
                            amp_disable[i] <= 1'b1;
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/reg_read_mux.sv
// ------------------------------
// registered read-back of commanded currents and the amp disable status
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module reg_read_mux (
    input  wire                       sysclk,
    input  wire                       arst_n,
    input  wire motor_ctrl_pkg::addr_t     raddr,
    input  wire motor_ctrl_pkg::cur_t      cur_cmd [motor_ctrl_pkg::NUM_CHANNELS],
    input  wire motor_ctrl_pkg::amp_mask_t amp_disable,
    output motor_ctrl_pkg::data_t          rdata
);
    import motor_ctrl_pkg::*;

    chan_t     rd_chan;
    chan_idx_t rd_idx;
    data_t     rd_next;

    assign rd_chan = raddr[7:4];
    assign rd_idx  = chan_idx_t'(rd_chan - chan_t'(1));

    // unmapped addresses read as zero
    always_comb begin
        rd_next = '0;
        if (raddr[15:12] == ADDR_MAIN) begin
            if ((rd_chan == chan_t'(0)) && (raddr[3:0] == OFF_STATUS)) begin
                rd_next = data_t'(amp_disable);         // low bits
            end else if ((rd_chan != chan_t'(0)) && (rd_chan <= chan_t'(NUM_CHANNELS)) &&
                         (raddr[3:0] == OFF_DAC_CTRL)) begin
                rd_next = data_t'(cur_cmd[rd_idx]);     // zero extended
            end
        end
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
        end else begin
            rdata <= rd_next;   // valid one cycle after raddr
        end
    end

endmodule

`default_nettype wire

//--- logic/motor_ctrl_top.sv
// ------------------------------
// command path top: arbiter, command regs, serial DAC, safety check and read-back
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module motor_ctrl_top (
    input  wire                       sysclk,
    input  wire                       arst_n,
    input  wire motor_ctrl_pkg::wr_bus_t   fw_wr,
    input  wire motor_ctrl_pkg::wr_bus_t   eth_wr,
    input  wire motor_ctrl_pkg::wr_bus_t   bw_wr,
    input  wire                       eth_write_en,
    input  wire                       bw_write_en,
    input  wire motor_ctrl_pkg::addr_t     raddr,
    input  wire motor_ctrl_pkg::cur_t      cur_fb [motor_ctrl_pkg::NUM_CHANNELS],
    input  wire                       cur_ready,
    output motor_ctrl_pkg::data_t          rdata,
    output motor_ctrl_pkg::amp_mask_t      amp_disable,
    output logic                      dac_sclk,
    output logic                      dac_mosi,
    output logic                      dac_csel
);
    import motor_ctrl_pkg::*;

    wr_bus_t wr_bus;                    // registered, shared by all writers
    cur_t    cur_cmd [NUM_CHANNELS];
    logic    dac_busy;
    logic    dac_update;

    // ------------------------------
    // write path
    // ------------------------------
    write_bus_arbiter write_bus_arbiter_inst (
        .sysclk       (sysclk),
        .arst_n       (arst_n),
        .fw_wr        (fw_wr),
        .eth_wr       (eth_wr),
        .bw_wr        (bw_wr),
        .eth_write_en (eth_write_en),
        .bw_write_en  (bw_write_en),
        .wr_bus       (wr_bus)
    );

    cur_cmd_regs cur_cmd_regs_inst (
        .sysclk     (sysclk),
        .arst_n     (arst_n),
        .wr_bus     (wr_bus),
        .dac_busy   (dac_busy),     // back-pressure
        .cur_cmd    (cur_cmd),
        .dac_update (dac_update)
    );

    dac_serializer dac_serializer_inst (
        .sysclk     (sysclk),
        .arst_n     (arst_n),
        .cur_cmd    (cur_cmd),
        .dac_update (dac_update),
        .dac_busy   (dac_busy),
        .dac_sclk   (dac_sclk),
        .dac_mosi   (dac_mosi),
        .dac_csel   (dac_csel)
    );

    // ------------------------------
    // side stages
    // ------------------------------
    safety_monitor safety_monitor_inst (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .wr_bus      (wr_bus),      // status clear
        .cur_cmd     (cur_cmd),
        .cur_fb      (cur_fb),
        .cur_ready   (cur_ready),
        .amp_disable (amp_disable)
    );

    reg_read_mux reg_read_mux_inst (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .raddr       (raddr),
        .cur_cmd     (cur_cmd),
        .amp_disable (amp_disable),
        .rdata       (rdata)
    );

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
// ------------------------------
// testbench clock and reset source: 4 ns sysclk, arst_n low for the first 4 cycles
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic sysclk,
    output logic arst_n
);

    initial begin
        sysclk = 1'b0;
        arst_n = 1'b0;                  // in reset from time zero
        repeat (4) @(posedge sysclk);
        arst_n <= 1'b1;                 // release on a rising edge
    end

    always #2 sysclk = ~sysclk;         // 250 MHz

endmodule

`default_nettype wire

//--- tb/motor_ctrl_tb.sv
// ------------------------------
// testbench for the command path; replays the golden script against the DUT
// run from the project root so the script path resolves
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module motor_ctrl_tb;
    import motor_ctrl_pkg::*;

    logic        sysclk;
    logic        arst_n;
    wr_bus_t     fw_wr;
    wr_bus_t     eth_wr;
    wr_bus_t     bw_wr;
    logic        eth_write_en;
    logic        bw_write_en;
    addr_t       raddr;
    cur_t        cur_fb [NUM_CHANNELS];
    logic        cur_ready;
    data_t       rdata;
    amp_mask_t   amp_disable;
    logic        dac_sclk;
    logic        dac_mosi;
    logic        dac_csel;

    dac_frame_t  frames [$];                // received DAC frames in arrival order
    dac_frame_t  rx_frame;
    int          rx_bits;
    cur_t        model_cmd [NUM_CHANNELS];  // expected command per channel
    logic [31:0] rng_state;
    int          wait_limit;                // cycles per wait loop
    string       test_name;
    string       line;
    string       op;
    int          fd;
    int          n;
    logic [31:0] v0, v1, v2, v3, v4, v5;
    data_t       win_data;

    tb_clock_gen tb_clock_gen_inst (
        .sysclk (sysclk),
        .arst_n (arst_n)
    );

    motor_ctrl_top motor_ctrl_top_inst (
        .sysclk       (sysclk),
        .arst_n       (arst_n),
        .fw_wr        (fw_wr),
        .eth_wr       (eth_wr),
        .bw_wr        (bw_wr),
        .eth_write_en (eth_write_en),
        .bw_write_en  (bw_write_en),
        .raddr        (raddr),
        .cur_fb       (cur_fb),
        .cur_ready    (cur_ready),
        .rdata        (rdata),
        .amp_disable  (amp_disable),
        .dac_sclk     (dac_sclk),
        .dac_mosi     (dac_mosi),
        .dac_csel     (dac_csel)
    );

    // ------------------------------
    // serial DAC monitor
    // ------------------------------
    always @(posedge dac_sclk) begin
        if (!dac_csel) begin                // only bits inside a frame
            rx_frame = {rx_frame[DAC_FRAME_BITS-2:0], dac_mosi};
            rx_bits  = rx_bits + 1;
            if (rx_bits == DAC_FRAME_BITS) begin
                frames.push_back(rx_frame);
                rx_bits = 0;
            end
        end
    end

    // every frame must end right after its last bit
    always @(posedge dac_csel) begin
        if (rx_bits != 0) begin
            fail_run($sformatf("DAC frame ended with %0d bits left over", rx_bits));
        end
    end

    // ------------------------------
    // reporting
    // ------------------------------
    task automatic fail_run(input string what);
        $display("ERROR: %s", what);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s (%s): expected %h, actual %h",
                     test_name, what, expected, actual);
            fail_run("value check failed");
        end
    endtask

    // xorshift32 step
    function automatic logic [31:0] next_random(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // feedback whose distance from midscale stays within 2x cmd distance + margin
    function automatic cur_t in_limit_value(input cur_t cmd, input logic [31:0] rnd);
        logic [15:0] cmd_dist;
        logic [16:0] limit;
        logic [15:0] span;
        cmd_dist = (cmd >= CUR_MID) ? cmd - CUR_MID : CUR_MID - cmd;
        limit    = {cmd_dist, 1'b0} + {1'b0, SAFETY_MARGIN};
        if (limit > 17'h7fff) begin
            limit = 17'h7fff;               // keep mid +- span inside 16 bits
        end
        span = rnd[15:0] % (limit[15:0] + 16'd1);
        return rnd[16] ? CUR_MID + span : CUR_MID - span;
    endfunction

    // ------------------------------
    // drivers
    // ------------------------------
    // src bit0 fw, bit1 eth_en, bit2 bw_en; kind bit0 reg_wen, bit1 blk_wen
    task automatic drive_write(input logic [2:0] src, input logic [1:0] kind,
                               input addr_t addr, input data_t d_fw,
                               input data_t d_eth, input data_t d_bw);
        wr_bus_t bus;
        bus         = '0;
        bus.reg_wen = kind[0];
        bus.blk_wen = kind[1];
        bus.addr    = addr;
        @(posedge sysclk);
        if (src[0]) begin
            bus.data = d_fw;
            fw_wr   <= bus;
        end
        if (src[1]) begin
            bus.data = d_eth;
            eth_wr  <= bus;
        end
        if (src[2]) begin
            bus.data = d_bw;
            bw_wr   <= bus;
        end
        eth_write_en <= src[1];
        bw_write_en  <= src[2];
        @(posedge sysclk);                  // merged bus registered here
        fw_wr        <= '0;
        eth_wr       <= '0;
        bw_wr        <= '0;
        eth_write_en <= 1'b0;
        bw_write_en  <= 1'b0;
        @(posedge sysclk);                  // write has landed
    endtask

    task automatic drive_sample(input cur_t f1, input cur_t f2, input cur_t f3, input cur_t f4);
        @(posedge sysclk);
        cur_fb[0] <= f1;
        cur_fb[1] <= f2;
        cur_fb[2] <= f3;
        cur_fb[3] <= f4;
        cur_ready <= 1'b1;
        @(posedge sysclk);
        cur_ready <= 1'b0;
    endtask

    task automatic drive_filler_sample();
        cur_t fb [NUM_CHANNELS];
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            rng_state = next_random(rng_state);
            fb[i]     = in_limit_value(model_cmd[i], rng_state);
        end
        drive_sample(fb[0], fb[1], fb[2], fb[3]);
    endtask

    task automatic check_read(input addr_t addr, input data_t expected);
        @(posedge sysclk);
        raddr <= addr;
        @(posedge sysclk);
        @(negedge sysclk);                  // rdata settled
        check_value($sformatf("read %h", addr), expected, rdata);
    endtask

    // ------------------------------
    // DAC waits and checks
    // ------------------------------
    task automatic wait_frames(input int count);
        int cycles;
        cycles = 0;
        while (frames.size() < count) begin
            @(negedge sysclk);
            cycles++;
            if (cycles > wait_limit) begin
                fail_run("timed out waiting for DAC frames");
            end
        end
    endtask

    task automatic wait_busy_low();
        int cycles;
        cycles = 0;
        @(negedge sysclk);
        while (motor_ctrl_top_inst.dac_busy !== 1'b0) begin
            @(negedge sysclk);
            cycles++;
            if (cycles > wait_limit) begin
                fail_run("timed out waiting for the DAC to go idle");
            end
        end
    endtask

    task automatic check_dac_update(input cur_t c1, input cur_t c2,
                                    input cur_t c3, input cur_t c4);
        cur_t       exp_cmd [NUM_CHANNELS];
        dac_frame_t frame;
        exp_cmd[0] = c1;
        exp_cmd[1] = c2;
        exp_cmd[2] = c3;
        exp_cmd[3] = c4;
        wait_frames(NUM_CHANNELS);
        wait_busy_low();
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            frame = frames.pop_front();
            check_value($sformatf("dac frame %0d", i + 1),
                        data_t'({chan_t'(i + 1), exp_cmd[i]}), data_t'(frame));
        end
    endtask

    task automatic check_dac_idle(input int cycles);
        repeat (cycles) @(negedge sysclk);
        check_value("extra dac frames", 0, frames.size());
        check_value("dac busy", 0, data_t'(motor_ctrl_top_inst.dac_busy));
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (arst_n !== 1'b1) begin
            @(negedge sysclk);
            cycles++;
            if (cycles > wait_limit) begin
                fail_run("reset was never released");
            end
        end
    endtask

    // ------------------------------
    // script player
    // ------------------------------
    initial begin
        fw_wr        <= '0;
        eth_wr       <= '0;
        bw_wr        <= '0;
        eth_write_en <= 1'b0;
        bw_write_en  <= 1'b0;
        raddr        <= '0;
        cur_ready    <= 1'b0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            cur_fb[i]    <= CUR_MID;
            model_cmd[i]  = CUR_MID;
        end
        rx_bits    = 0;
        rx_frame   = '0;
        rng_state  = 32'd49;
        wait_limit = 2000;
        test_name  = "reset";

        wait_reset_release();
        @(negedge sysclk);
        check_value("rdata", 0, rdata);
        check_value("amp_disable", 0, data_t'(amp_disable));
        check_value("dac_csel", 1, data_t'(dac_csel));
        check_value("dac_sclk", 0, data_t'(dac_sclk));

        fd = $fopen("tb/motor_ctrl_golden.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open the golden script");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0) begin
                break;
            end
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;                   // blank or column notes
            end
            n = $sscanf(line, "%s", op);
            if (op == "T") begin
                n = $sscanf(line, "%s %s", op, test_name);
            end else begin
                n = $sscanf(line, "%s %h %h %h %h %h %h", op, v0, v1, v2, v3, v4, v5);
                if (op == "W") begin
                    drive_write(v0[2:0], v1[1:0], v2[15:0], v3, v4, v5);
                    // bw over eth over fw
                    win_data = v0[2] ? v5 : (v0[1] ? v4 : v3);
                    if (v1[0] && v2[15:12] == ADDR_MAIN && v2[3:0] == OFF_DAC_CTRL &&
                        v2[7:4] >= 1 && v2[7:4] <= NUM_CHANNELS) begin
                        model_cmd[v2[7:4] - 1] = win_data[15:0];
                    end
                end else if (op == "R") begin
                    check_read(v0[15:0], v1);
                end else if (op == "F") begin
                    drive_sample(v0[15:0], v1[15:0], v2[15:0], v3[15:0]);
                end else if (op == "I") begin
                    drive_filler_sample();
                end else if (op == "D") begin
                    check_dac_update(v0[15:0], v1[15:0], v2[15:0], v3[15:0]);
                end else if (op == "Z") begin
                    check_dac_idle(v0);
                end else if (op == "A") begin
                    @(negedge sysclk);
                    check_value("amp_disable", v0, data_t'(amp_disable));
                end else begin
                    fail_run($sformatf("unknown operation in golden script: %s", op));
                end
            end
        end
        $fclose(fd);

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/motor_ctrl_golden.txt
# W src(1 fw,2 eth_en,4 bw_en) kind(1 reg,2 blk) addr fw_data eth_data bw_data | T name
# R addr rdata | F fb1..fb4 | I filler sample | D cmd1..cmd4 | Z idle_cycles | A amp_disable
T priority
W 7 1 0011 1111 2222 3333
R 0011 3333
W 3 1 0011 4444 5555 0
R 0011 5555
W 1 1 0011 6666 0 0
R 0011 6666
T decode
W 1 1 0001 dead 0 0
W 1 1 0051 beef 0 0
W 1 1 0012 1234 0 0
W 1 1 1011 4321 0 0
R 0011 6666
R 0021 8000
R 0031 8000
R 0041 8000
R 0001 0
R 0051 0
R 0012 0
R 1011 0
T dac_update
W 1 1 0011 9001 0 0
W 1 1 0021 7002 0 0
W 1 1 0031 a003 0 0
W 1 3 0041 5004 0 0
D 9001 7002 a003 5004
Z 80
T back_pressure
W 1 1 0011 0a0a 0 0
W 1 3 0041 0b0b 0 0
W 1 3 0021 1234 0 0
W 1 3 0031 4321 0 0
W 1 3 0021 5678 0 0
D 0a0a 7002 a003 0b0b
D 0a0a 5678 4321 0b0b
Z 80
T safety
W 1 1 0011 8100 0 0
F 8400 8000 fff0 8000
F 8400 8000 fff0 8000
F 8400 8000 fff0 8000
I
F 8400 8000 fff0 8000
F 8400 8000 fff0 8000
F 8400 8000 fff0 8000
A 0
R 0000 0
F 8400 8000 fff0 8000
A 5
R 0000 5
W 1 1 0000 1 0 0
A 4
R 0000 4
R 0011 8100
W 1 1 0000 4 0 0
A 0
R 0000 0

//--- sources.f
logic/motor_ctrl_pkg.sv
logic/write_bus_arbiter.sv
logic/cur_cmd_regs.sv
logic/dac_serializer.sv
logic/safety_monitor.sv
logic/reg_read_mux.sv
logic/motor_ctrl_top.sv
tb/tb_clock_gen.sv
tb/motor_ctrl_tb.sv

//--- Bender.yml
package:
  name: motor_ctrl

sources:
  - logic/motor_ctrl_pkg.sv
  - logic/write_bus_arbiter.sv
  - logic/cur_cmd_regs.sv
  - logic/dac_serializer.sv
  - logic/safety_monitor.sv
  - logic/reg_read_mux.sv
  - logic/motor_ctrl_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/motor_ctrl_tb.sv
